//--- design/tnn_pkg.sv
`default_nettype none

package tnn_pkg;

    localparam int FEAT_CNT   = 19;
    localparam int FEAT_BITS  = 4;
    localparam int HIDDEN_CNT = 40;
    localparam int CLASS_CNT  = 3;
    localparam int CLASS_BITS = 2;
    localparam int SUM_BITS   = 10;  // +-19*15 plus sign
    localparam int SCORE_BITS = 7;   // up to 2*HIDDEN_CNT

    // two random masks, bit index is h*FEAT_CNT + f
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] W1_RAW_A = {
        40'h3a91c07e5d, 40'h8f24b6e013, 40'hc57d0a9e42, 40'h1b6f38d7a0, 40'he04c9b2f75,
        40'h962d5e1ac8, 40'h4fb3071d9e, 40'ha8e6c24b31, 40'h07d5f9a36c, 40'hd23b84e0f7,
        40'h5c19ae6d20, 40'h71f4d0b89a, 40'hb06a2c5e3d, 40'h2e8d7f4193, 40'hf95c13b6a4,
        40'h684a0e2dcf, 40'hc3b71f5809, 40'h0d6e9a47b2, 40'h9a2f65c18e
    };
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] W1_RAW_B = {
        40'hd4c8127fa6, 40'h60e3b95d1c, 40'h2bf0748ec9, 40'h9e5a13c46d, 40'h37b8d0f25a,
        40'hc16f4a8e03, 40'h5e0d92b7f4, 40'h8a37e1c60b, 40'hf2c59b0d48, 40'h4b8e6f13a7,
        40'ha075dc29e1, 40'h13eb8f6c5d, 40'h6dc4a3907e, 40'hb9f1e20c84, 40'h0e6a5d7b39,
        40'hfd12c8a6e5, 40'h2790be4d1f, 40'h84df36a0c2, 40'he5b0c97f16
    };

    // ternary weights, +1 and -1 masks are disjoint by construction
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] W1_POS = W1_RAW_A & ~W1_RAW_B;
    localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] W1_NEG = W1_RAW_B & ~W1_RAW_A;

    // binary class weights, class 2 first, bit index is c*HIDDEN_CNT + j
    localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] W2_SIGN = {
        40'h5a3c96e10b, 40'h2d7e841fc5, 40'hb4196ad0e3
    };
    localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] W2_USE = {
        40'hf7b3ed96af, 40'hdbf6a7ce9b, 40'h7fe9b5dd6e
    };

    function automatic logic [CLASS_CNT-1:0][7:0] count_zero_weights();
        logic [CLASS_CNT-1:0][7:0] cnt;
        cnt = '0;
        for (int c = 0; c < CLASS_CNT; c++) begin
            for (int j = 0; j < HIDDEN_CNT; j++) begin
                if (!W2_USE[c*HIDDEN_CNT+j]) begin
                    cnt[c] = cnt[c] + 8'd1;
                end
            end
        end
        return cnt;
    endfunction

    localparam logic [CLASS_CNT-1:0][7:0] ZERO_CNT = count_zero_weights();

    function automatic logic [7:0] min_zero_count();
        logic [7:0] m;
        m = ZERO_CNT[0];
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (ZERO_CNT[c] < m) begin
                m = ZERO_CNT[c];
            end
        end
        return m;
    endfunction

    localparam logic [7:0] MIN_ZERO_CNT = min_zero_count();

    typedef struct packed {
        logic [FEAT_CNT-1:0][FEAT_BITS-1:0] features;
        logic                               valid;
    } feature_vec_t;

    typedef struct packed {
        logic [HIDDEN_CNT-1:0] bits;
        logic                  valid;
    } hidden_vec_t;

    typedef struct packed {
        logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score;
        logic                                 valid;
    } score_vec_t;

endpackage

`default_nettype wire

//--- design/hidden_layer.sv
`timescale 1ns/1ns
`default_nettype none

module hidden_layer (
    input  logic                  clk,
    input  logic                  reset,
    input  tnn_pkg::feature_vec_t feature_in,
    output tnn_pkg::hidden_vec_t  hidden_out
);
    import tnn_pkg::*;

    logic [HIDDEN_CNT-1:0] hidden_bits;
    logic [HIDDEN_CNT-1:0] bits_q;
    logic                  valid_q;

    // sign test of one neuron's ternary weighted sum
    function automatic logic neuron_fires(
        input int unsigned                        h,
        input logic [FEAT_CNT-1:0][FEAT_BITS-1:0] feats
    );
        logic signed [SUM_BITS-1:0] sum;
        logic signed [SUM_BITS-1:0] term;
        sum = '0;
        for (int f = 0; f < FEAT_CNT; f++) begin
            term = SUM_BITS'(feats[f]);  // features are unsigned
            if (W1_POS[h*FEAT_CNT+f]) begin
                sum = sum + term;
            end else if (W1_NEG[h*FEAT_CNT+f]) begin
                sum = sum - term;
            end
        end
        return sum >= 0;
    endfunction

    always_comb begin
        for (int h = 0; h < HIDDEN_CNT; h++) begin
            hidden_bits[h] = neuron_fires(h, feature_in.features);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= feature_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        bits_q <= hidden_bits;  // don't care while valid is low
    end

    assign hidden_out = {bits_q, valid_q};

endmodule

`default_nettype wire

//--- design/class_scorer.sv
`timescale 1ns/1ns
`default_nettype none

module class_scorer (
    input  logic                 clk,
    input  logic                 reset,
    input  tnn_pkg::hidden_vec_t hidden_in,
    output tnn_pkg::score_vec_t  score_out
);
    import tnn_pkg::*;

    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score_d;
    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score_q;
    logic                                 valid_q;

    // agreement count over used weights, then zero weight correction
    function automatic logic [SCORE_BITS-1:0] class_score(
        input int unsigned           c,
        input logic [HIDDEN_CNT-1:0] hid
    );
        logic [SCORE_BITS-1:0] agree;
        agree = '0;
        for (int j = 0; j < HIDDEN_CNT; j++) begin
            if (W2_USE[c*HIDDEN_CNT+j] && (hid[j] == W2_SIGN[c*HIDDEN_CNT+j])) begin
                agree = agree + SCORE_BITS'(1);
            end
        end
        return SCORE_BITS'(2 * agree + ZERO_CNT[c] - MIN_ZERO_CNT);
    endfunction

    always_comb begin
        for (int c = 0; c < CLASS_CNT; c++) begin
            score_d[c] = class_score(c, hidden_in.bits);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hidden_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        score_q <= score_d;
    end

    assign score_out = {score_q, valid_q};

endmodule

`default_nettype wire

//--- design/argmax_select.sv
`timescale 1ns/1ns
`default_nettype none

module argmax_select (
    input  logic                           clk,
    input  logic                           reset,
    input  tnn_pkg::score_vec_t            score_in,
    output logic [tnn_pkg::CLASS_BITS-1:0] prediction,
    output logic                           out_valid
);
    import tnn_pkg::*;

    logic [SCORE_BITS-1:0] best_score;
    logic [CLASS_BITS-1:0] best_idx;

    always_comb begin
        best_idx   = '0;
        best_score = score_in.score[0];
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (score_in.score[c] > best_score) begin  // strict, ties keep lower index
                best_score = score_in.score[c];
                best_idx   = CLASS_BITS'(c);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= score_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        prediction <= best_idx;
    end

endmodule

`default_nettype wire

//--- design/tnn_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module tnn_classifier (
    input  logic                                              clk,
    input  logic                                              reset,
    input  logic                                              in_valid,
    input  logic [tnn_pkg::FEAT_CNT*tnn_pkg::FEAT_BITS-1:0]   features,
    output logic [tnn_pkg::CLASS_BITS-1:0]                    prediction,
    output logic                                              out_valid
);
    import tnn_pkg::*;

    feature_vec_t feature_vec;
    hidden_vec_t  hidden_vec;
    score_vec_t   score_vec;

    assign feature_vec = {features, in_valid};  // feature 0 in the low nibble

    // stage 1, ternary hidden layer
    hidden_layer u_hidden (
        .clk        (clk),
        .reset      (reset),
        .feature_in (feature_vec),
        .hidden_out (hidden_vec)
    );

    // stage 2, per class scores
    class_scorer u_scorer (
        .clk       (clk),
        .reset     (reset),
        .hidden_in (hidden_vec),
        .score_out (score_vec)
    );

    // stage 3
    argmax_select u_argmax (
        .clk        (clk),
        .reset      (reset),
        .score_in   (score_vec),
        .prediction (prediction),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

//--- testbench/tnn_properties.sv
`timescale 1ns/1ns
`default_nettype none

module tnn_properties (
    input logic                           clk,
    input logic                           reset,
    input logic                           in_valid,
    input logic [tnn_pkg::CLASS_BITS-1:0] prediction,
    input logic                           out_valid
);
    import tnn_pkg::*;

    int missing_fails  = 0;
    int spurious_fails = 0;
    int reset_fails    = 0;
    int range_fails    = 0;

    // every accepted record comes out three edges later
    assert property (@(posedge clk) disable iff (reset) $past(in_valid, 3) |-> out_valid)
        else begin
            $error("out_valid missing three cycles after an accepted record");
            missing_fails++;
        end

    assert property (@(posedge clk) disable iff (reset) out_valid |-> $past(in_valid, 3))
        else begin
            $error("out_valid high without a record accepted three cycles earlier");
            spurious_fails++;
        end

    // covers the reset cycles and the first cycle after reset
    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high during or right after reset");
            reset_fails++;
        end

    assert property (@(posedge clk) disable iff (reset) out_valid |-> (int'(prediction) < CLASS_CNT))
        else begin
            $error("prediction outside the class range");
            range_fails++;
        end

endmodule

bind tnn_classifier tnn_properties props0 (.*);

`default_nettype wire

//--- testbench/tnn_tb.sv
`timescale 1ns/1ns
`default_nettype none

module tnn_tb;
    import tnn_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int LATENCY      = 3;
    localparam int MARGIN       = 50;
    localparam int RAND_RECS    = 300;
    localparam int CORNER_RECS  = 2 + 2 * FEAT_CNT;
    localparam int FEAT_W       = FEAT_CNT * FEAT_BITS;
    // a record takes at most two cycles, one with in_valid and one idle gap
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * (RAND_RECS + CORNER_RECS) + LATENCY + MARGIN;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic [FEAT_W-1:0]     features;
    logic [CLASS_BITS-1:0] prediction;
    logic                  out_valid;

    logic [CLASS_BITS-1:0] expect_q[$];  // model results in send order
    logic [CLASS_BITS-1:0] expected;
    int                    sb_errors   = 0;
    int                    checked_cnt = 0;
    int                    sent_cnt    = 0;
    int                    cycle_cnt   = 0;
    int                    count_errors;
    int                    prop_errors;

    always #5 clk = ~clk;

    tnn_classifier dut0 (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .features   (features),
        .prediction (prediction),
        .out_valid  (out_valid)
    );

    // software model of the network
    function automatic logic [CLASS_BITS-1:0] predict_class(input logic [FEAT_W-1:0] rec);
        logic [HIDDEN_CNT-1:0] hid;
        int                    scores [CLASS_CNT];
        int                    zeros [CLASS_CNT];
        int                    sum;
        int                    agree;
        int                    min_zeros;
        int                    best;
        for (int h = 0; h < HIDDEN_CNT; h++) begin
            sum = 0;
            for (int f = 0; f < FEAT_CNT; f++) begin
                if (W1_POS[h*FEAT_CNT+f]) begin
                    sum += int'(rec[f*FEAT_BITS +: FEAT_BITS]);
                end else if (W1_NEG[h*FEAT_CNT+f]) begin
                    sum -= int'(rec[f*FEAT_BITS +: FEAT_BITS]);
                end
            end
            hid[h] = (sum >= 0);
        end
        for (int c = 0; c < CLASS_CNT; c++) begin
            agree    = 0;
            zeros[c] = 0;
            for (int j = 0; j < HIDDEN_CNT; j++) begin
                if (!W2_USE[c*HIDDEN_CNT+j]) begin
                    zeros[c]++;
                end else if (hid[j] == W2_SIGN[c*HIDDEN_CNT+j]) begin
                    agree++;
                end
            end
            scores[c] = 2 * agree + zeros[c];
        end
        min_zeros = zeros[0];
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (zeros[c] < min_zeros) min_zeros = zeros[c];
        end
        best = 0;
        for (int c = 1; c < CLASS_CNT; c++) begin
            if (scores[c] - min_zeros > scores[best] - min_zeros) best = c;  // lowest index wins ties
        end
        return CLASS_BITS'(best);
    endfunction

    function automatic logic [FEAT_W-1:0] random_record();
        logic [FEAT_W-1:0] rec;
        for (int f = 0; f < FEAT_CNT; f++) begin
            rec[f*FEAT_BITS +: FEAT_BITS] = FEAT_BITS'($urandom_range(0, 15));
        end
        return rec;
    endfunction

    // one in_valid cycle, optionally followed by an idle cycle
    task automatic send_record(input logic [FEAT_W-1:0] rec, input logic gap);
        @(posedge clk);
        in_valid <= 1'b1;
        features <= rec;
        expect_q.push_back(predict_class(rec));
        sent_cnt++;
        if (gap) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (out_valid) begin
            checked_cnt++;
            if (expect_q.size() == 0) begin
                $display("out_valid went high with no record pending");
                sb_errors++;
            end else begin
                expected = expect_q.pop_front();
                assert (prediction == expected)
                    else begin
                        $display("FAILED prediction: got 0x%0h, expected 0x%0h",
                                 prediction, expected);
                        sb_errors++;
                    end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d results still pending",
                     cycle_cnt, expect_q.size());
            $display("Test failures found");
            $finish;
        end
    end

    initial begin
        logic [FEAT_W-1:0] rec;
        void'($urandom(32'h5248));
        reset    = 1'b1;
        in_valid = 1'b0;
        features = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        // corner records back to back
        send_record('0, 1'b0);
        send_record('1, 1'b0);
        for (int f = 0; f < FEAT_CNT; f++) begin
            rec = '0;
            rec[f*FEAT_BITS +: FEAT_BITS] = 4'hf;  // single hot feature
            send_record(rec, 1'b0);
        end
        for (int f = 0; f < FEAT_CNT; f++) begin
            rec = '1;
            rec[f*FEAT_BITS +: FEAT_BITS] = 4'h0;  // single cold feature
            send_record(rec, 1'b0);
        end

        for (int i = 0; i < RAND_RECS; i++) begin
            send_record(random_record(), 1'($urandom_range(0, 1)));
        end
        @(posedge clk);
        in_valid <= 1'b0;

        while (expect_q.size() != 0) @(posedge clk);
        repeat (LATENCY + 2) @(posedge clk);  // catch any extra out_valid

        if (checked_cnt != sent_cnt) begin
            $display("result count mismatch, %0d records sent and %0d results seen",
                     sent_cnt, checked_cnt);
            count_errors = 1;
        end else begin
            count_errors = 0;
        end
        prop_errors = dut0.props0.missing_fails + dut0.props0.spurious_fails
                    + dut0.props0.reset_fails + dut0.props0.range_fails;
        $display("errors: scoreboard %0d, result count %0d, properties %0d (%0d records)",
                 sb_errors, count_errors, prop_errors, sent_cnt);
        if (sb_errors + count_errors + prop_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
design/tnn_pkg.sv
design/hidden_layer.sv
design/class_scorer.sv
design/argmax_select.sv
design/tnn_classifier.sv
testbench/tnn_properties.sv
testbench/tnn_tb.sv

//--- Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := tnn_tb
FILELIST  := project.f
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := All tests passed!
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
